// ==== include/cp0_config.svh ====
`ifndef CP0_CONFIG_SVH
`define CP0_CONFIG_SVH

`define CP0_XLEN 32

// Register addresses as {rd, sel}
`define CP0_ADDR_BADVADDR 8'h40 // rd 8, sel 0
`define CP0_ADDR_COUNT    8'h48 // rd 9, sel 0
`define CP0_ADDR_COMPARE  8'h58 // rd 11, sel 0
`define CP0_ADDR_STATUS   8'h60 // rd 12, sel 0
`define CP0_ADDR_CAUSE    8'h68 // rd 13, sel 0
`define CP0_ADDR_EPC      8'h70 // rd 14, sel 0
`define CP0_ADDR_EBASE    8'h79 // rd 15, sel 1

// Exception vector base while Bev is set
`define CP0_BOOT_BASE 32'hBFC0_0200

// EBase value out of reset, kseg0
`define CP0_EBASE_RESET 32'h8000_0000

// General exception offset from either base
`define CP0_EXC_OFFSET 32'h180

// Compare parks at the top of the count range
`define CP0_COMPARE_RESET 32'hFFFF_FFFF

`endif

// ==== design/cp0_pkg.sv ====
`include "cp0_config.svh"

package cp0_pkg;

    typedef logic [`CP0_XLEN-1:0] word_t;

    typedef logic [7:0] reg_addr_t; // {rd, sel}

    typedef logic [4:0] exc_code_t; // Cause.ExcCode

    typedef logic [7:0] irq_vec_t; // IP or IM byte

    typedef logic [5:0] ext_irq_t; // Hardware interrupt pins

    // Exception kind reported by the memory stage
    typedef enum logic [3:0] {
        EXC_NONE,
        EXC_INT,
        EXC_ADEL,
        EXC_ADES,
        EXC_SYS,
        EXC_BP,
        EXC_RI,
        EXC_CPU,
        EXC_OV,
        EXC_TRAP
    } exc_type_t;

endpackage

// ==== design/cp0_exc_ctrl.sv ====
`include "cp0_config.svh"

module cp0_exc_ctrl (
    input  logic               valid,
    input  logic               inst_mtc0,
    input  logic               inst_eret,
    input  logic               in_delay_slot,
    input  logic               ex,
    input  cp0_pkg::exc_type_t exc_type,
    input  cp0_pkg::word_t     pc,
    input  cp0_pkg::word_t     alu_result,
    input  logic               status_exl,
    input  logic               status_bev,
    input  cp0_pkg::word_t     ebase,
    output logic               mtc0_we,
    output logic               ex_take,
    output logic               eret_flush,
    output cp0_pkg::exc_code_t exc_code,
    output cp0_pkg::word_t     epc_next,
    output logic               badvaddr_we,
    output cp0_pkg::word_t     badvaddr_next,
    output cp0_pkg::word_t     exc_entry
);
    import cp0_pkg::*;

    word_t exc_base;

    assign mtc0_we    = valid && inst_mtc0 && !ex;
    assign eret_flush = valid && inst_eret && !ex;
    assign ex_take    = ex && !status_exl; // Nested entry keeps EPC and BD

    always_comb begin
        case (exc_type)
            EXC_INT:  exc_code = 5'd0;
            EXC_ADEL: exc_code = 5'd4;
            EXC_ADES: exc_code = 5'd5;
            EXC_SYS:  exc_code = 5'd8;
            EXC_BP:   exc_code = 5'd9;
            EXC_RI:   exc_code = 5'd10;
            EXC_CPU:  exc_code = 5'd11;
            EXC_OV:   exc_code = 5'd12;
            EXC_TRAP: exc_code = 5'd13;
            default:  exc_code = 5'd0; // NONE, not latched by Cause
        endcase
    end

    always_comb begin
        if (exc_type == EXC_INT && inst_mtc0) begin
            epc_next = pc + 32'd4; // Resume after the mtc0 that unmasked it
        end else if (in_delay_slot) begin
            epc_next = pc - 32'd4; // Point at the branch
        end else begin
            epc_next = pc;
        end
    end

    assign badvaddr_we = ex && (exc_type == EXC_ADEL || exc_type == EXC_ADES);

    always_comb begin
        if (exc_type == EXC_ADEL && pc[1:0] != 2'b00) begin
            badvaddr_next = pc; // Fetch fault
        end else begin
            badvaddr_next = alu_result; // Load or store address
        end
    end

    assign exc_base  = status_bev ? `CP0_BOOT_BASE : ebase;
    assign exc_entry = exc_base + `CP0_EXC_OFFSET;

    // At most one commit action per instruction
    always_comb begin
        assert ($onehot0({mtc0_we, eret_flush, ex}));
    end

endmodule

// ==== design/cp0_regs.sv ====
`include "cp0_config.svh"

module cp0_regs (
    input  logic               clk,
    input  logic               reset,
    input  logic               mtc0_we,
    input  logic [4:0]         rd,
    input  logic [2:0]         sel,
    input  cp0_pkg::word_t     wdata_in,
    input  logic               ex,
    input  logic               ex_take,
    input  cp0_pkg::exc_type_t exc_type,
    input  cp0_pkg::exc_code_t exc_code,
    input  logic               in_delay_slot,
    input  cp0_pkg::word_t     epc_next,
    input  logic               badvaddr_we,
    input  cp0_pkg::word_t     badvaddr_next,
    input  logic               eret_flush,
    input  cp0_pkg::ext_irq_t  ext_int,
    input  cp0_pkg::word_t     count,
    input  cp0_pkg::word_t     compare,
    input  logic               timer_irq,
    output cp0_pkg::word_t     rdata,
    output logic               status_ie,
    output logic               status_exl,
    output logic               status_bev,
    output cp0_pkg::irq_vec_t  status_im,
    output cp0_pkg::irq_vec_t  cause_ip,
    output cp0_pkg::word_t     epc,
    output cp0_pkg::word_t     ebase,
    output logic               count_we,
    output logic               compare_we,
    output cp0_pkg::word_t     wdata
);
    import cp0_pkg::*;

    reg_addr_t addr;
    logic      wr_status;
    logic      wr_cause;
    logic      wr_epc;
    logic      wr_ebase;
    logic      cause_bd;
    logic      cause_ce;
    exc_code_t cause_exc_code;
    word_t     badvaddr;

    assign addr      = {rd, sel};
    assign wr_status = mtc0_we && (addr == `CP0_ADDR_STATUS);
    assign wr_cause  = mtc0_we && (addr == `CP0_ADDR_CAUSE);
    assign wr_epc    = mtc0_we && (addr == `CP0_ADDR_EPC);
    assign wr_ebase  = mtc0_we && (addr == `CP0_ADDR_EBASE);

    assign count_we   = mtc0_we && (addr == `CP0_ADDR_COUNT); // Count lives in the timer
    assign compare_we = mtc0_we && (addr == `CP0_ADDR_COMPARE);
    assign wdata      = wdata_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            status_bev <= 1'b1;
            status_im  <= '0;
            status_ie  <= 1'b0;
            status_exl <= 1'b0;
        end else begin
            if (wr_status) begin
                status_bev <= wdata_in[22];
                status_im  <= wdata_in[15:8];
                status_ie  <= wdata_in[0];
            end
            if (ex) begin
                status_exl <= 1'b1; // Set even when already in EXL
            end else if (eret_flush) begin
                status_exl <= 1'b0;
            end else if (wr_status) begin
                status_exl <= wdata_in[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd       <= 1'b0;
            cause_ce       <= 1'b0;
            cause_exc_code <= '0;
            cause_ip       <= '0;
        end else begin
            if (ex_take) begin
                cause_bd <= in_delay_slot; // Only on first-level entry
            end
            if (ex && exc_type == EXC_CPU) begin
                cause_ce <= 1'b1;
            end
            if (ex && exc_type != EXC_NONE) begin
                cause_exc_code <= exc_code;
            end
            cause_ip[7]   <= ext_int[5] | timer_irq; // Timer shares the top line
            cause_ip[6:2] <= ext_int[4:0];
            if (wr_cause) begin
                cause_ip[1:0] <= wdata_in[9:8]; // Software interrupts
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_take) begin
            epc <= epc_next;
        end else if (wr_epc) begin
            epc <= wdata_in;
        end
        if (badvaddr_we) begin
            badvaddr <= badvaddr_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ebase <= `CP0_EBASE_RESET;
        end else if (wr_ebase) begin
            ebase[29:12] <= wdata_in[29:12]; // Exception base field only
        end
    end

    always_comb begin
        case (addr)
            `CP0_ADDR_STATUS:   rdata = {9'b0, status_bev, 6'b0, status_im, 6'b0,
                                         status_exl, status_ie};
            `CP0_ADDR_CAUSE:    rdata = {cause_bd, timer_irq, 1'b0, cause_ce, 12'b0, cause_ip,
                                         1'b0, cause_exc_code, 2'b0};
            `CP0_ADDR_EPC:      rdata = epc;
            `CP0_ADDR_BADVADDR: rdata = badvaddr;
            `CP0_ADDR_COUNT:    rdata = count;
            `CP0_ADDR_COMPARE:  rdata = compare;
            `CP0_ADDR_EBASE:    rdata = ebase;
            default:            rdata = '0;
        endcase
    end

    // Any committed exception leaves the core in exception level
    assert property (@(posedge clk) disable iff (reset) ex |=> status_exl);

endmodule

// ==== design/cp0_timer.sv ====
`include "cp0_config.svh"

module cp0_timer (
    input  logic           clk,
    input  logic           reset,
    input  logic           count_we,
    input  logic           compare_we,
    input  cp0_pkg::word_t wdata,
    output cp0_pkg::word_t count,
    output cp0_pkg::word_t compare,
    output logic           timer_irq
);
    logic tick;

    always_ff @(posedge clk) begin
        if (reset) begin
            tick <= 1'b0;
        end else begin
            tick <= ~tick; // Half-rate count enable
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (count_we) begin
            count <= wdata;
        end else if (tick) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare   <= `CP0_COMPARE_RESET;
            timer_irq <= 1'b0;
        end else if (compare_we) begin
            compare   <= wdata;
            timer_irq <= 1'b0; // Writing Compare acknowledges TI
        end else if (count == compare) begin
            timer_irq <= 1'b1; // Sticky until next Compare write
        end
    end

    assert property (@(posedge clk) disable iff (reset) compare_we |=> !timer_irq);

endmodule

// ==== design/cp0_top.sv ====
module cp0_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               valid,
    input  logic               inst_mtc0,
    input  logic               inst_eret,
    input  logic               in_delay_slot,
    input  logic               ex,
    input  cp0_pkg::exc_type_t exc_type,
    input  cp0_pkg::word_t     pc,
    input  cp0_pkg::word_t     alu_result,
    input  logic [4:0]         rd,
    input  logic [2:0]         sel,
    input  cp0_pkg::ext_irq_t  ext_int,
    output cp0_pkg::word_t     rdata,
    output logic               eret_flush,
    output cp0_pkg::word_t     exc_entry,
    output cp0_pkg::word_t     epc,
    output logic               status_ie,
    output logic               status_exl,
    output cp0_pkg::irq_vec_t  status_im,
    output cp0_pkg::irq_vec_t  cause_ip,
    output logic               timer_irq
);
    import cp0_pkg::*;

    logic      mtc0_we;
    logic      ex_take;
    logic      badvaddr_we;
    logic      status_bev;
    logic      count_we;
    logic      compare_we;
    exc_code_t exc_code;
    word_t     epc_next;
    word_t     badvaddr_next;
    word_t     ebase;
    word_t     wdata;
    word_t     count;
    word_t     compare;

    cp0_exc_ctrl i_exc_ctrl (
        .valid(valid), .inst_mtc0(inst_mtc0), .inst_eret(inst_eret),
        .in_delay_slot(in_delay_slot), .ex(ex), .exc_type(exc_type),
        .pc(pc), .alu_result(alu_result), .status_exl(status_exl),
        .status_bev(status_bev), .ebase(ebase), .mtc0_we(mtc0_we),
        .ex_take(ex_take), .eret_flush(eret_flush), .exc_code(exc_code),
        .epc_next(epc_next), .badvaddr_we(badvaddr_we),
        .badvaddr_next(badvaddr_next), .exc_entry(exc_entry)
    );

    cp0_regs i_regs (
        .clk(clk), .reset(reset), .mtc0_we(mtc0_we), .rd(rd), .sel(sel),
        .wdata_in(alu_result), .ex(ex), .ex_take(ex_take), .exc_type(exc_type),
        .exc_code(exc_code), .in_delay_slot(in_delay_slot), .epc_next(epc_next),
        .badvaddr_we(badvaddr_we), .badvaddr_next(badvaddr_next),
        .eret_flush(eret_flush), .ext_int(ext_int), .count(count),
        .compare(compare), .timer_irq(timer_irq), .rdata(rdata),
        .status_ie(status_ie), .status_exl(status_exl), .status_bev(status_bev),
        .status_im(status_im), .cause_ip(cause_ip), .epc(epc), .ebase(ebase),
        .count_we(count_we), .compare_we(compare_we), .wdata(wdata)
    );

    cp0_timer i_timer (
        .clk(clk), .reset(reset), .count_we(count_we), .compare_we(compare_we),
        .wdata(wdata), .count(count), .compare(compare), .timer_irq(timer_irq)
    );

endmodule

// ==== dv/tb_cp0.sv ====
`include "cp0_config.svh"

module tb_cp0;
    import cp0_pkg::*;

    localparam int    RESET_CYCLES = 10;
    localparam string STIM_FILE    = "dv/cp0_stim.txt";

    logic       clk;
    logic       reset;
    logic       valid;
    logic       inst_mtc0;
    logic       inst_eret;
    logic       in_delay_slot;
    logic       ex;
    exc_type_t  exc_type;
    word_t      pc;
    word_t      alu_result;
    logic [4:0] rd;
    logic [2:0] sel;
    ext_irq_t   ext_int;
    word_t      rdata;
    logic       eret_flush;
    word_t      exc_entry;
    word_t      epc;
    logic       status_ie;
    logic       status_exl;
    irq_vec_t   status_im;
    irq_vec_t   cause_ip;
    logic       timer_irq;

    logic [7:0] op_q[$];
    word_t      arg_q[$]; // Five fields per stim line
    int         cycle_count = 0;
    int         cycle_limit = 1000000;
    int         checks_done = 0;

    cp0_top i_dut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the run hung", cycle_limit);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(string what, word_t got, word_t want);
        $display("** Error at time %0t: %s, got %h, expected %h", $time, what, got, want);
        stop_with_failure();
    endtask

    task automatic check_word(word_t got, word_t want, string what);
        checks_done++;
        if (got !== want) report_mismatch(what, got, want);
    endtask

    task automatic check_word_window(word_t got, word_t lo, word_t hi, string what);
        checks_done++;
        if (got < lo || got > hi) begin
            $display("** Error at time %0t: %s, got %h, expected %h..%h",
                     $time, what, got, lo, hi);
            stop_with_failure();
        end
    endtask

    task automatic check_code(exc_code_t got, exc_code_t want, string what);
        checks_done++;
        if (got !== want) report_mismatch(what, word_t'(got), word_t'(want));
    endtask

    task automatic check_irq(irq_vec_t got, irq_vec_t want, string what);
        checks_done++;
        if (got !== want) report_mismatch(what, word_t'(got), word_t'(want));
    endtask

    task automatic check_bit(logic got, logic want, string what);
        checks_done++;
        if (got !== want) report_mismatch(what, word_t'(got), word_t'(want));
    endtask

    task automatic drive_idle();
        valid         = 1'b0;
        inst_mtc0     = 1'b0;
        inst_eret     = 1'b0;
        in_delay_slot = 1'b0;
        ex            = 1'b0;
        exc_type      = EXC_NONE;
        pc            = '0;
        alu_result    = $urandom; // Filler, no write is enabled
        {rd, sel}     = 8'h00;
    endtask

    task automatic do_write(word_t addr, word_t data);
        @(negedge clk);
        drive_idle();
        valid      = 1'b1;
        inst_mtc0  = 1'b1;
        {rd, sel}  = addr[7:0];
        alu_result = data;
        #2;
        check_bit(eret_flush, 1'b0, "eret_flush during mtc0");
    endtask

    task automatic do_read(word_t addr, word_t want, word_t tol);
        @(negedge clk);
        drive_idle();
        {rd, sel} = addr[7:0];
        #2;
        if (addr[7:0] == `CP0_ADDR_CAUSE) check_code(rdata[6:2], want[6:2], "Cause.ExcCode");
        if (addr[7:0] == `CP0_ADDR_STATUS) begin
            check_bit(status_exl, want[1], "status_exl port");
            check_bit(status_ie, want[0], "status_ie port");
            check_irq(status_im, want[15:8], "status_im port");
        end
        if (addr[7:0] == `CP0_ADDR_EPC) check_word(epc, want, "epc port");
        if (tol != 0) begin
            check_word_window(rdata, want - tol, want + tol,
                              $sformatf("mfc0 window at %h", addr[7:0]));
        end else begin
            check_word(rdata, want, $sformatf("mfc0 at %h", addr[7:0]));
        end
    endtask

    task automatic do_exception(word_t kind, word_t flags, word_t pc_val, word_t alu_val,
                                word_t entry);
        @(negedge clk);
        drive_idle();
        valid         = 1'b1;
        ex            = 1'b1;
        exc_type      = exc_type_t'(kind[3:0]);
        in_delay_slot = flags[0];
        inst_mtc0     = flags[1];
        inst_eret     = flags[2];
        pc            = pc_val;
        alu_result    = alu_val;
        {rd, sel}     = `CP0_ADDR_STATUS; // A leaked mtc0 would land on Status
        #2;
        check_word(exc_entry, entry, "exc_entry");
        check_bit(eret_flush, 1'b0, "eret_flush with ex");
    endtask

    task automatic do_eret();
        @(negedge clk);
        drive_idle();
        valid     = 1'b1;
        inst_eret = 1'b1;
        #2;
        check_bit(eret_flush, 1'b1, "eret_flush on eret");
    endtask

    task automatic do_irq(word_t ext, word_t ip_new, word_t ip_old);
        @(negedge clk);
        drive_idle();
        ext_int = ext[5:0];
        #2;
        check_irq(cause_ip, ip_old[7:0], "cause_ip before the edge");
        @(posedge clk);
        #2;
        check_irq(cause_ip, ip_new[7:0], "cause_ip after the edge");
    endtask

    task automatic do_idle(word_t cycles, word_t chk, word_t ti, word_t ip);
        repeat (cycles) begin
            @(negedge clk);
            drive_idle();
        end
        #2;
        if (chk != 0) begin
            check_bit(timer_irq, ti[0], "timer_irq");
            check_irq(cause_ip, ip[7:0], "cause_ip");
        end
    endtask

    task automatic load_stim();
        int    fd;
        int    n;
        int    line_no;
        int    max_idle;
        string line;
        word_t f[5];
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
            stop_with_failure();
        end
        line_no  = 0;
        max_idle = 0;
        while ($fgets(line, fd) > 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") continue;
            n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4]);
            if (n != 5) begin
                $display("Stimulus line %0d has %0d fields instead of 5", line_no, n);
                stop_with_failure();
            end
            op_q.push_back(line.getc(0));
            foreach (f[i]) arg_q.push_back(f[i]);
            if (line.getc(0) == "N" && f[0] > max_idle) max_idle = f[0];
        end
        $fclose(fd);
        cycle_limit = op_q.size() * (max_idle + 4) + RESET_CYCLES;
    endtask

    initial begin
        int unsigned seed;
        int          base;
        seed    = $urandom(32'h239f_5767);
        reset   = 1'b1;
        ext_int = '0;
        drive_idle();
        load_stim();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        foreach (op_q[i]) begin
            base = i * 5;
            case (op_q[i])
                "W": do_write(arg_q[base], arg_q[base + 1]);
                "R": do_read(arg_q[base], arg_q[base + 1], arg_q[base + 2]);
                "X": do_exception(arg_q[base], arg_q[base + 1], arg_q[base + 2],
                                  arg_q[base + 3], arg_q[base + 4]);
                "E": do_eret();
                "I": do_irq(arg_q[base], arg_q[base + 1], arg_q[base + 2]);
                "N": do_idle(arg_q[base], arg_q[base + 1], arg_q[base + 2], arg_q[base + 3]);
                default: begin
                    $display("Unknown operation '%c' in stimulus entry %0d", op_q[i], i);
                    stop_with_failure();
                end
            endcase
        end
        @(negedge clk);
        if (checks_done == 0) begin
            $display("No checks ran, the stimulus file holds no operations");
            stop_with_failure();
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== dv/cp0_stim.txt ====
# op f1 f2 f3 f4 f5, all hex, unused fields 0. W addr data | R addr expect tol | E
# X type flags(eret,mtc0,bd) pc alu entry | I ext ip_new ip_old | N cycles chk ti ip
R 48 00000001 00000001 0 0
R 60 00400000 0 0 0
R 68 00000000 0 0 0
R 58 FFFFFFFF 0 0 0
R 79 80000000 0 0 0
R 78 00000000 0 0 0
W 60 FFFFFFFF 0 0 0
R 60 0040FF03 0 0 0
W 60 1000FF11 0 0 0
W 70 BFC01234 0 0 0
R 70 BFC01234 0 0 0
W 79 FFFFFFFF 0 0 0
R 79 BFFFF000 0 0 0
W 79 00012345 0 0 0
W 68 FFFFFFFF 0 0 0
R 68 00000300 0 0 0
X 4 1 80002004 00000000 80012180
R 68 80000320 0 0 0
X 6 0 80003000 00000000 80012180
R 68 80000328 0 0 0
R 70 80002000 0 0 0
E 0 0 0 0 0
R 60 0000FF01 0 0 0
X 7 0 80004000 00000000 80012180
R 68 1000032C 0 0 0
X 2 0 80005002 12345678 80012180
R 40 80005002 0 0 0
X 2 0 80005004 00000ABD 80012180
R 40 00000ABD 0 0 0
X 3 0 80006003 0000BEE2 80012180
R 40 0000BEE2 0 0 0
E 0 0 0 0 0
X 1 2 80007000 00000000 80012180
R 60 0000FF03 0 0 0
X 5 4 80008000 00000000 80012180
R 70 80007004 0 0 0
E 0 0 0 0 0
W 60 0040FF01 0 0 0
X 9 0 80009000 00000000 BFC00380
R 68 10000334 0 0 0
E 0 0 0 0 0
W 48 00000100 0 0 0
N A 0 0 0 0
R 48 00000105 00000001 0 0
W 48 00000200 0 0 0
W 58 00000208 0 0 0
R 58 00000208 0 0 0
N 8 1 0 03 0
N 10 1 1 83 0
R 68 50008334 0 0 0
W 58 FFFFFFFF 0 0 0
N 1 1 0 83 0
N 1 1 0 03 0
I 15 57 03 0 0
I 2A AB 57 0 0
W 68 00000100 0 0 0
R 68 1000A934 0 0 0
I 00 01 A9 0 0

// ==== tb.f ====
+incdir+include
design/cp0_pkg.sv
design/cp0_exc_ctrl.sv
design/cp0_regs.sv
design/cp0_timer.sv
design/cp0_top.sv
dv/tb_cp0.sv

// ==== Makefile ====
# Verilator flow for the CP0 testbench, run from the project root

VERILATOR ?= verilator
TOP       ?= tb_cp0
RTL_TOP   ?= cp0_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINTFLAGS) +incdir+include design/cp0_pkg.sv design/cp0_exc_ctrl.sv \
		design/cp0_regs.sv design/cp0_timer.sv design/cp0_top.sv --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST OK" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
